// File: source/zx_paging_pkg.sv
// Spectrum paging core definitions
package zx_paging_pkg;

	localparam int PHYS_ADDR_W = 25;

	typedef logic [PHYS_ADDR_W-1:0] phys_addr_t;
	typedef logic [15:0]            cpu_addr_t;
	typedef logic [7:0]             cpu_data_t;
	typedef logic [2:0]             border_t;

	// Machine model, sampled during reset
	typedef enum logic [1:0] {
		MODEL_48K   = 2'd0,
		MODEL_128K  = 2'd1,
		MODEL_PLUS3 = 2'd2
	} model_t;

	typedef enum logic [1:0] {
		EV_MEM_RD = 2'd0,
		EV_MEM_WR = 2'd1,
		EV_IO_WR  = 2'd2
	} event_kind_t;

	// ================================================
	// Views of an I/O write byte
	// ================================================
	typedef struct packed {
		logic [1:0] spare;
		logic       lock;
		logic       rom;
		logic       screen;
		logic [2:0] bank;
	} p7ffd_t;

	// cfg[1] doubles as the high ROM select in normal mode
	typedef struct packed {
		logic [4:0] spare;
		logic [1:0] cfg;
		logic       special;
	} p1ffd_t;

	typedef struct packed {
		logic [2:0] spare;
		logic       ear;
		logic       mic;
		border_t    border;
	} ula_t;

	typedef union packed {
		p7ffd_t p7ffd;
		p1ffd_t p1ffd;
		ula_t   ula;
	} port_byte_u;

	// Fixed RAM banks behind 4000 and 8000
	localparam logic [2:0] BANK_SCREEN = 3'd5;
	localparam logic [2:0] BANK_MID    = 3'd2;

endpackage

// File: source/bus_event_if.sv
// Captured bus event channel
interface bus_event_if;

	// One-cycle strobe per event
	logic                        valid;
	zx_paging_pkg::event_kind_t kind;
	zx_paging_pkg::cpu_addr_t   addr;
	zx_paging_pkg::cpu_data_t   data;

	modport src (
		output valid,
		output kind,
		output addr,
		output data
	);

	modport dst (
		input valid,
		input kind,
		input addr,
		input data
	);

endinterface

// File: source/map_req_if.sv
// Memory event with paging state
interface map_req_if;

	logic                       valid;
	logic                       write;
	zx_paging_pkg::cpu_addr_t   addr;
	zx_paging_pkg::cpu_data_t   data;
	// Paging snapshot taken when the event left the port stage
	zx_paging_pkg::port_byte_u page_7ffd;
	zx_paging_pkg::port_byte_u page_1ffd;
	zx_paging_pkg::model_t     model;

	modport src (
		output valid, write, addr, data,
		output page_7ffd, page_1ffd, model
	);

	modport dst (
		input valid, write, addr, data,
		input page_7ffd, page_1ffd, model
	);

endinterface

// File: source/bus_capture.sv
// Bus cycle start detector
module bus_capture (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  zx_paging_pkg::cpu_addr_t addr,
	input  zx_paging_pkg::cpu_data_t data,
	input  logic                     mreq,
	input  logic                     iorq,
	input  logic                     rd,
	input  logic                     wr,
	input  logic                     m1,
	bus_event_if.src                 ev
);

	logic mem_lvl;
	logic io_wr_lvl;
	logic mem_prev;
	logic io_wr_prev;
	logic mem_start;
	logic io_wr_start;

	// Refresh has mreq without rd or wr, so it never counts
	assign mem_lvl   = mreq & (rd | wr);
	// I/O write outside of an interrupt acknowledge
	assign io_wr_lvl = iorq & wr & ~m1;

	assign mem_start   = mem_lvl & ~mem_prev;
	assign io_wr_start = io_wr_lvl & ~io_wr_prev;

	// ================================================
	// Edge detect
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_prev   <= 1'b0;
			io_wr_prev <= 1'b0;
			ev.valid   <= 1'b0;
		end else begin
			mem_prev   <= mem_lvl;
			io_wr_prev <= io_wr_lvl;
			ev.valid   <= mem_start | io_wr_start;
		end
	end

	// Event payload
	always_ff @(posedge clk_sys) begin
		if (mem_start) begin
			ev.kind <= wr ? zx_paging_pkg::EV_MEM_WR : zx_paging_pkg::EV_MEM_RD;
			ev.addr <= addr;
			ev.data <= data;
		end else if (io_wr_start) begin
			ev.kind <= zx_paging_pkg::EV_IO_WR;
			ev.addr <= addr;
			ev.data <= data;
		end
	end

endmodule

// File: source/port_regs.sv
// Port decode and paging registers
module port_regs (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  zx_paging_pkg::model_t    model,
	bus_event_if.dst                 ev,
	map_req_if.src                   req,
	output zx_paging_pkg::border_t   border,
	output logic                     ear,
	output logic                     mic,
	output logic                     screen_page
);

	zx_paging_pkg::model_t     model_q;
	zx_paging_pkg::port_byte_u page_7ffd;
	zx_paging_pkg::port_byte_u page_1ffd;
	zx_paging_pkg::port_byte_u wr_byte;
	logic                      plus3;
	logic                      page_disable;
	logic                      io_wr;
	logic                      mem_ev;
	logic                      hit_ula;
	logic                      hit_7ffd;
	logic                      hit_1ffd;

	assign wr_byte = ev.data;
	assign plus3   = (model_q == zx_paging_pkg::MODEL_PLUS3);

	// 48K has no paging; the lock bit freezes it until reset
	assign page_disable = (model_q == zx_paging_pkg::MODEL_48K) | page_7ffd.p7ffd.lock;

	assign io_wr  = ev.valid & (ev.kind == zx_paging_pkg::EV_IO_WR);
	assign mem_ev = ev.valid & (ev.kind != zx_paging_pkg::EV_IO_WR);

	// ================================================
	// Port decode
	// ================================================
	assign hit_ula  = io_wr & ~ev.addr[0];
	// 128K only looks at A15 and A1, +3 adds A14
	assign hit_7ffd = io_wr & ~ev.addr[15] & ~ev.addr[1] & (ev.addr[14] | ~plus3)
		& ~page_disable;
	assign hit_1ffd = io_wr & ~ev.addr[1] & ev.addr[12] & (ev.addr[15:13] == 3'b000)
		& plus3 & ~page_disable;

	// Model sampled while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_7ffd <= '0;
			page_1ffd <= '0;
			border    <= '0;
			ear       <= 1'b0;
			mic       <= 1'b0;
		end else begin
			// A single write may land in the ULA and a paging port
			if (hit_ula) begin
				border <= wr_byte.ula.border;
				ear    <= wr_byte.ula.ear;
				mic    <= wr_byte.ula.mic;
			end
			if (hit_7ffd) begin
				page_7ffd <= wr_byte;
			end
			if (hit_1ffd) begin
				page_1ffd <= wr_byte;
			end
		end
	end

	assign screen_page = page_7ffd.p7ffd.screen;

	// ================================================
	// Memory event forwarding
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req.valid <= 1'b0;
		end else begin
			req.valid <= mem_ev;
		end
	end

	// Paging state travels with the access
	always_ff @(posedge clk_sys) begin
		if (mem_ev) begin
			req.write     <= (ev.kind == zx_paging_pkg::EV_MEM_WR);
			req.addr      <= ev.addr;
			req.data      <= ev.data;
			req.page_7ffd <= page_7ffd;
			req.page_1ffd <= page_1ffd;
			req.model     <= model_q;
		end
	end

endmodule

// File: source/mem_map.sv
// Logical to physical memory mapper
module mem_map #(
	parameter zx_paging_pkg::phys_addr_t ROM_BASE = 25'h100000
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	map_req_if.dst                     req,
	output logic                       mem_req,
	output logic                       mem_we,
	output logic                       rom_access,
	output zx_paging_pkg::phys_addr_t  mem_addr,
	output zx_paging_pkg::cpu_data_t   mem_data
);

	logic [1:0]                quadrant;
	logic                      special;
	logic [2:0]                rom_page;
	logic [2:0]                bank;
	logic                      is_rom;
	zx_paging_pkg::phys_addr_t phys;

	// +3 all-RAM layouts, indexed by config and quadrant
	function automatic logic [2:0] special_bank(input logic [1:0] cfg, input logic [1:0] quad);
		logic [2:0] b;
		case (cfg)
			2'd0: b = {1'b0, quad};
			2'd1: b = {1'b1, quad};
			2'd2: b = (quad == 2'd3) ? 3'd3 : {1'b1, quad};
			default: begin
				case (quad)
					2'd0: b = 3'd4;
					2'd1: b = 3'd7;
					2'd2: b = 3'd6;
					default: b = 3'd3;
				endcase
			end
		endcase
		return b;
	endfunction

	assign quadrant = req.addr[15:14];
	assign special  = req.page_1ffd.p1ffd.special;

	// ================================================
	// Translation
	// ================================================
	always_comb begin
		case (req.model)
			zx_paging_pkg::MODEL_48K:   rom_page = 3'd1;
			zx_paging_pkg::MODEL_PLUS3: rom_page = {1'b1, req.page_1ffd.p1ffd.cfg[1],
				req.page_7ffd.p7ffd.rom};
			default:                    rom_page = {2'b00, req.page_7ffd.p7ffd.rom};
		endcase

		if (special) begin
			bank = special_bank(req.page_1ffd.p1ffd.cfg, quadrant);
		end else begin
			case (quadrant)
				2'd1: bank = zx_paging_pkg::BANK_SCREEN;
				2'd2: bank = zx_paging_pkg::BANK_MID;
				2'd3: bank = req.page_7ffd.p7ffd.bank;
				default: bank = 3'd0;
			endcase
		end

		is_rom = ~special & (quadrant == 2'd0);
		if (is_rom) begin
			phys = ROM_BASE + zx_paging_pkg::phys_addr_t'({rom_page, req.addr[13:0]});
		end else begin
			phys = zx_paging_pkg::phys_addr_t'({bank, req.addr[13:0]});
		end
	end

	// Output register, ROM writes are dropped here
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_req    <= 1'b0;
			mem_we     <= 1'b0;
			rom_access <= 1'b0;
		end else begin
			mem_req    <= req.valid;
			mem_we     <= req.valid & req.write & ~is_rom;
			rom_access <= req.valid & is_rom;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req.valid) begin
			mem_addr <= phys;
			mem_data <= req.data;
		end
	end

endmodule

// File: source/zx_paging.sv
// Spectrum paging core top
module zx_paging #(
	parameter zx_paging_pkg::phys_addr_t ROM_BASE = 25'h100000
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  zx_paging_pkg::model_t     model,
	input  zx_paging_pkg::cpu_addr_t  addr,
	input  zx_paging_pkg::cpu_data_t  data,
	input  logic                      mreq,
	input  logic                      iorq,
	input  logic                      rd,
	input  logic                      wr,
	input  logic                      m1,
	output logic                      mem_req,
	output zx_paging_pkg::phys_addr_t mem_addr,
	output logic                      mem_we,
	output zx_paging_pkg::cpu_data_t  mem_data,
	output logic                      rom_access,
	output zx_paging_pkg::border_t    border,
	output logic                      ear,
	output logic                      mic,
	output logic                      screen_page
);

	bus_event_if ev_if ();
	map_req_if   req_if ();

	// ================================================
	// Three stage pipeline
	// ================================================
	bus_capture u_capture (
		.clk_sys (clk_sys),
		.reset   (reset),
		.addr    (addr),
		.data    (data),
		.mreq    (mreq),
		.iorq    (iorq),
		.rd      (rd),
		.wr      (wr),
		.m1      (m1),
		.ev      (ev_if.src)
	);

	port_regs u_ports (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model       (model),
		.ev          (ev_if.dst),
		.req         (req_if.src),
		.border      (border),
		.ear         (ear),
		.mic         (mic),
		.screen_page (screen_page)
	);

	mem_map #(
		.ROM_BASE (ROM_BASE)
	) u_map (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.req        (req_if.dst),
		.mem_req    (mem_req),
		.mem_we     (mem_we),
		.rom_access (rom_access),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data)
	);

endmodule

// File: dv/zx_paging_chk.sv
// Mapper output checks
module zx_paging_chk (
	input logic clk_sys,
	input logic reset,
	input logic mem_req,
	input logic mem_we,
	input logic rom_access
);

	// A write strobe only rides on a request
	we_needs_req: assert property (@(posedge clk_sys) disable iff (reset)
		mem_we |-> mem_req)
		else $error("mem_we high without mem_req");

	// Requests are single cycle pulses
	req_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		mem_req |=> !mem_req)
		else $error("mem_req held for more than one cycle");

	// ROM is never written
	no_rom_write: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem_we && rom_access))
		else $error("mem_we and rom_access high together");

endmodule

bind mem_map zx_paging_chk u_chk (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.mem_req    (mem_req),
	.mem_we     (mem_we),
	.rom_access (rom_access)
);

// File: dv/zx_paging_tb.sv
// Paging core testbench
module zx_paging_tb;

	localparam int MEM_TIMEOUT = 20;
	localparam int MEM_LATENCY = 3;

	// One trace line
	typedef struct packed {
		logic [7:0]                op;
		zx_paging_pkg::cpu_addr_t  addr;
		zx_paging_pkg::cpu_data_t  data;
		zx_paging_pkg::phys_addr_t phys;
		logic                      we;
		logic                      rom;
		zx_paging_pkg::border_t    border;
		logic                      ear;
		logic                      mic;
		logic                      scr;
	} trace_op_t;

	logic                      clk_sys = 1'b0;
	logic                      reset;
	zx_paging_pkg::model_t     model;
	zx_paging_pkg::cpu_addr_t  addr;
	zx_paging_pkg::cpu_data_t  data;
	logic                      mreq;
	logic                      iorq;
	logic                      rd;
	logic                      wr;
	logic                      m1;
	logic                      mem_req;
	logic                      mem_we;
	logic                      rom_access;
	zx_paging_pkg::phys_addr_t mem_addr;
	zx_paging_pkg::cpu_data_t  mem_data;
	zx_paging_pkg::border_t    border;
	logic                      ear;
	logic                      mic;
	logic                      screen_page;

	zx_paging dut (
		.clk_sys (clk_sys), .reset (reset), .model (model), .addr (addr), .data (data),
		.mreq (mreq), .iorq (iorq), .rd (rd), .wr (wr), .m1 (m1),
		.mem_req (mem_req), .mem_addr (mem_addr), .mem_we (mem_we), .mem_data (mem_data),
		.rom_access (rom_access), .border (border), .ear (ear), .mic (mic),
		.screen_page (screen_page)
	);

	always #5 clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ================================================
	// Error reporting and compares
	// ================================================
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_border(input zx_paging_pkg::border_t got,
		input zx_paging_pkg::border_t exp);
		if (got !== exp)
			stop_run($sformatf("FAIL %0t border got %0d expected %0d", $time, got, exp));
	endtask

	task automatic check_data(input zx_paging_pkg::cpu_data_t got,
		input zx_paging_pkg::cpu_data_t exp);
		if (got !== exp)
			stop_run($sformatf("FAIL %0t mem_data got %h expected %h", $time, got, exp));
	endtask

	task automatic check_mem(input zx_paging_pkg::phys_addr_t got_addr, input logic got_we,
		input zx_paging_pkg::phys_addr_t exp_addr, input logic exp_we);
		if (got_addr !== exp_addr)
			stop_run($sformatf("FAIL %0t mem_addr got %h expected %h", $time, got_addr, exp_addr));
		check_bit("mem_we", got_we, exp_we);
	endtask

	task automatic check_port_outputs(input zx_paging_pkg::border_t e_border,
		input logic e_ear, input logic e_mic, input logic e_scr);
		check_border(border, e_border);
		check_bit("ear", ear, e_ear);
		check_bit("mic", mic, e_mic);
		check_bit("screen_page", screen_page, e_scr);
	endtask

	// ================================================
	// Bus operations
	// ================================================
	task automatic release_bus();
		mreq = 1'b0;
		iorq = 1'b0;
		rd   = 1'b0;
		wr   = 1'b0;
		m1   = 1'b0;
	endtask

	task automatic apply_reset(input zx_paging_pkg::model_t m);
		reset = 1'b1;
		model = m;
		release_bus();
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic drive_io_write(input zx_paging_pkg::cpu_addr_t a,
		input zx_paging_pkg::cpu_data_t d);
		addr = a;
		data = d;
		iorq = 1'b1;
		wr   = 1'b1;
		m1   = 1'b0;
	endtask

	// Levels stay up until the request shows, which is when outputs are checked
	// With io_en the bus drops after the start and an I/O write follows 2 cycles later
	task automatic mem_access(input logic write, input zx_paging_pkg::cpu_addr_t a,
		input zx_paging_pkg::cpu_data_t d, input zx_paging_pkg::phys_addr_t exp_addr,
		input logic exp_we, input logic exp_rom, input logic io_en,
		input zx_paging_pkg::cpu_addr_t io_a, input zx_paging_pkg::cpu_data_t io_d);
		int   cycles;
		logic seen;
		addr   = a;
		data   = d;
		mreq   = 1'b1;
		rd     = ~write;
		wr     = write;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < MEM_TIMEOUT) begin
			@(negedge clk_sys);
			cycles++;
			seen = (mem_req === 1'b1);
			if (io_en && cycles == 1)
				release_bus();
			if (io_en && cycles == 2)
				drive_io_write(io_a, io_d);
		end
		if (!seen)
			stop_run($sformatf("Timeout: no memory request for the access to %h", a));
		if (cycles != MEM_LATENCY)
			stop_run($sformatf("Memory request came %0d cycles after its start, not %0d",
				cycles, MEM_LATENCY));
		check_mem(mem_addr, mem_we, exp_addr, exp_we);
		if (exp_we)
			check_data(mem_data, d);
		check_bit("rom_access", rom_access, exp_rom);
		release_bus();
	endtask

	task automatic io_write(input zx_paging_pkg::cpu_addr_t a,
		input zx_paging_pkg::cpu_data_t d);
		drive_io_write(a, d);
		@(negedge clk_sys);
		release_bus();
	endtask

	initial begin
		int                        fd;
		int                        rc;
		int                        n;
		int                        i;
		int                        gap;
		logic [31:0]               seed;
		string                     line;
		logic                      overlap;
		trace_op_t                 ops[$];
		trace_op_t                 t;
		trace_op_t                 nxt;
		logic [7:0]                op;
		zx_paging_pkg::cpu_addr_t  f_addr;
		zx_paging_pkg::cpu_data_t  f_data;
		zx_paging_pkg::phys_addr_t e_phys;
		logic                      e_we;
		logic                      e_rom;
		zx_paging_pkg::border_t    e_border;
		logic                      e_ear;
		logic                      e_mic;
		logic                      e_scr;
		reset = 1'b1;
		model = zx_paging_pkg::MODEL_128K;
		addr  = '0;
		data  = '0;
		release_bus();
		seed  = 32'h1ead82b2;
		fd    = $fopen("dv/zx_paging_trace.txt", "r");
		if (fd == 0)
			stop_run("Could not open the trace file dv/zx_paging_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			rc   = $fgets(line, fd);
			if (rc == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h", op, f_addr, f_data,
				e_phys, e_we, e_rom, e_border, e_ear, e_mic, e_scr);
			if (n != 10)
				stop_run($sformatf("Trace line could not be read: %s", line));
			t.op     = op;
			t.addr   = f_addr;
			t.data   = f_data;
			t.phys   = e_phys;
			t.we     = e_we;
			t.rom    = e_rom;
			t.border = e_border;
			t.ear    = e_ear;
			t.mic    = e_mic;
			t.scr    = e_scr;
			ops.push_back(t);
		end
		$fclose(fd);

		// ================================================
		// Trace replay
		// ================================================
		i = 0;
		while (i < ops.size()) begin
			t    = ops[i];
			seed = lcg_step(seed);
			gap  = 1 + int'(seed[31:30]);
			case (t.op)
				"R": begin
					apply_reset(zx_paging_pkg::model_t'(t.addr[1:0]));
					check_bit("mem_req", mem_req, 1'b0);
					check_port_outputs(t.border, t.ear, t.mic, t.scr);
					repeat (gap) @(negedge clk_sys);
				end
				"M", "W": begin
					nxt = t;
					if (i + 1 < ops.size())
						nxt = ops[i + 1];
					// A following I/O write goes out while this access is in flight
					overlap = (nxt.op == "O");
					mem_access(t.op == "W", t.addr, t.data, t.phys, t.we, t.rom,
						overlap, nxt.addr, nxt.data);
					check_port_outputs(t.border, t.ear, t.mic, t.scr);
					if (overlap) begin
						@(negedge clk_sys);
						check_port_outputs(nxt.border, nxt.ear, nxt.mic, nxt.scr);
						i++;
					end
					repeat (gap) @(negedge clk_sys);
				end
				"O": begin
					io_write(t.addr, t.data);
					// Port outputs settle 2 cycles after the start
					@(negedge clk_sys);
					check_port_outputs(t.border, t.ear, t.mic, t.scr);
					repeat (gap - 1) @(negedge clk_sys);
				end
				default: stop_run($sformatf("Unknown operation in trace line %0d", i));
			endcase
			i++;
		end
		if (ops.size() == 0) begin
			stop_run("The trace file held no operations");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

// File: zx_paging.f
source/zx_paging_pkg.sv
source/bus_event_if.sv
source/map_req_if.sv
source/bus_capture.sv
source/port_regs.sv
source/mem_map.sv
source/zx_paging.sv
dv/zx_paging_chk.sv
dv/zx_paging_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module zx_paging_tb -f zx_paging.f \
	-o zx_paging_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/zx_paging_sim > sim.log 2>&1
cat sim.log
grep -qF '*** PASSED ***' sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: dv/zx_paging_trace.txt
# op addr data, then expected: phys we rom border ear mic screen_page (all hex)
# R reset (addr = model 0 48K, 1 128K, 2 +3), M read, W write, O I/O write (mem columns unused)
R 0001 00 0000000 0 0 0 0 0 0
M 0000 00 0100000 0 1 0 0 0 0
M 4000 00 0014000 0 0 0 0 0 0
M 8000 00 0008000 0 0 0 0 0 0
M C000 00 0000000 0 0 0 0 0 0
W 0000 AA 0100000 0 1 0 0 0 0
W 4123 55 0014123 1 0 0 0 0 0
O 7FFD 08 0000000 0 0 0 0 0 1
O 7FFD 17 0000000 0 0 0 0 0 0
M C001 00 001C001 0 0 0 0 0 0
M 0002 00 0104002 0 1 0 0 0 0
O 7FFD 20 0000000 0 0 0 0 0 0
O 7FFD 17 0000000 0 0 0 0 0 0
M C000 00 0000000 0 0 0 0 0 0
O 00FE 1D 0000000 0 0 5 1 1 0
W 0000 33 0100000 0 1 5 1 1 0
R 0002 00 0000000 0 0 0 0 0 0
M 0000 00 0110000 0 1 0 0 0 0
O 00FE 02 0000000 0 0 2 0 0 0
O 1FFD 03 0000000 0 0 2 0 0 0
W 0010 11 0010010 1 0 2 0 0 0
M 4000 00 0014000 0 0 2 0 0 0
M 8000 00 0018000 0 0 2 0 0 0
M C000 00 001C000 0 0 2 0 0 0
O 1FFD 04 0000000 0 0 2 0 0 0
M 0000 00 0118000 0 1 2 0 0 0
O 7FFD 10 0000000 0 0 2 0 0 0
M 0005 00 011C005 0 1 2 0 0 0
R 0000 00 0000000 0 0 0 0 0 0
O 7FFD 0F 0000000 0 0 0 0 0 0
M C000 00 0000000 0 0 0 0 0 0
O 1FFD 01 0000000 0 0 0 0 0 0
M 0000 00 0104000 0 1 0 0 0 0
O 00FE 1D 0000000 0 0 5 1 1 0
M 4000 00 0014000 0 0 5 1 1 0
